/* verilog/vertex_cluster_pkg.sv */
/*
 * Vertex cluster shared definitions
 * Widths and unit count, job, read and result structs,
 * compute unit and dispatch state encodings
 */

`default_nettype none

package vertex_cluster_pkg;

	localparam int num_cu        = 4;
	localparam int vertex_bits   = 16;
	localparam int edge_bits     = 16;
	localparam int data_bits     = 32;
	localparam int tag_bits      = 2;
	localparam int count_bits    = 32;
	localparam int reset_stretch = 4;

	typedef struct packed {
		logic                   valid;
		logic [vertex_bits-1:0] vertex_id;
		logic [edge_bits-1:0]   edge_start;
		logic [edge_bits-1:0]   edge_count;
	} vertex_job_t;

	typedef struct packed {
		logic                 valid;
		logic [edge_bits-1:0] address;
		logic [tag_bits-1:0]  tag;
	} read_command_t;

	typedef struct packed {
		logic                 valid;
		logic [data_bits-1:0] data;
		logic [tag_bits-1:0]  tag;
	} read_data_t;

	typedef struct packed {
		logic                   valid;
		logic [vertex_bits-1:0] vertex_id;
		logic [data_bits-1:0]   value;
	} edge_write_t;

	typedef enum logic [2:0] {cu_idle, cu_wait_job, cu_issue, cu_drain, cu_write} cu_state_t;

	typedef enum logic [1:0] {arb_idle, arb_requested, arb_dispatch} arb_state_t;

endpackage

`default_nettype wire

/* verilog/cu_port_if.sv */
/*
 * Arbiter to compute unit port
 * Job hand-off, read command and grant, routed read data,
 * result write and grant, unit enable
 */

`timescale 1ns/1ps
`default_nettype none

interface cu_port_if;
	import vertex_cluster_pkg::*;

	// Unit side
	logic          job_request;
	read_command_t read_command;
	edge_write_t   edge_write;

	// Arbiter side, valids and grants are single-cycle pulses
	vertex_job_t job;
	logic        read_grant;
	logic        write_grant;
	read_data_t  read_data;
	logic        enable;

	modport arbiter (
		input  job_request, read_command, edge_write,
		output job, read_grant, write_grant, read_data, enable
	);

	modport unit (
		output job_request, read_command, edge_write,
		input  job, read_grant, write_grant, read_data, enable
	);

endinterface

`default_nettype wire

/* verilog/reset_sync.sv */
/*
 * Compute unit reset generator
 * Synchronized release, held for a few extra cycles
 */

`timescale 1ns/1ps
`default_nettype none

module reset_sync (
	input  logic clock,
	input  logic rstn_input,
	output logic cu_rstn
);
	import vertex_cluster_pkg::*;

	logic [1:0]                           sync_q;
	logic [$clog2(reset_stretch + 1)-1:0] stretch_count;

	// Assert at once, release only after the stretch count expires
	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			sync_q        <= '0;
			stretch_count <= '0;
			cu_rstn       <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
			if (sync_q[1] && stretch_count != reset_stretch) begin
				stretch_count <= stretch_count + 1'b1;
			end
			cu_rstn <= (stretch_count == reset_stretch);
		end
	end

endmodule

`default_nettype wire

/* verilog/vertex_spmv_unit.sv */
/*
 * SpMV compute unit
 * Requests a vertex job, issues one read per edge,
 * sums the returned words and posts one result write
 */

`timescale 1ns/1ps
`default_nettype none

module vertex_spmv_unit (
	input logic      clock,
	input logic      rstn_input,
	cu_port_if.unit  port
);
	import vertex_cluster_pkg::*;

	cu_state_t              state;
	logic [vertex_bits-1:0] vertex_id;
	logic [edge_bits-1:0]   next_address;
	logic [edge_bits-1:0]   issue_left;
	logic [edge_bits-1:0]   data_left;
	logic [data_bits-1:0]   sum;
	logic                   job_taken;

	assign job_taken = (state == cu_wait_job) && port.job.valid;

	//////////////////////////////
	// Unit FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			state <= cu_idle;
		end else begin
			case (state)
				cu_idle: begin
					if (port.enable) begin
						state <= cu_wait_job;
					end
				end
				cu_wait_job: begin
					// A job already on its way is taken even if the enable drops
					if (port.job.valid) begin
						if (port.job.edge_count == '0) begin
							state <= cu_write;
						end else begin
							state <= cu_issue;
						end
					end
				end
				cu_issue: begin
					if (port.read_grant && issue_left == 1) begin
						state <= cu_drain;
					end
				end
				cu_drain: begin
					if (data_left == '0) begin
						state <= cu_write;
					end
				end
				cu_write: begin
					if (port.write_grant) begin
						state <= cu_idle;
					end
				end
				default: begin
					state <= cu_idle;
				end
			endcase
		end
	end

	// Outstanding reads and data still due
	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			issue_left <= '0;
			data_left  <= '0;
		end else if (job_taken) begin
			issue_left <= port.job.edge_count;
			data_left  <= port.job.edge_count;
		end else begin
			if (port.read_grant) begin
				issue_left <= issue_left - 1'b1;
			end
			if (port.read_data.valid) begin
				data_left <= data_left - 1'b1;
			end
		end
	end

	// Address walk and running sum, wraps on overflow
	always_ff @(posedge clock) begin
		if (job_taken) begin
			vertex_id    <= port.job.vertex_id;
			next_address <= port.job.edge_start;
			sum          <= '0;
		end else begin
			if (port.read_grant) begin
				next_address <= next_address + 1'b1;
			end
			if (port.read_data.valid) begin
				sum <= sum + port.read_data.data;
			end
		end
	end

	//////////////////////////////
	// Port drive
	//////////////////////////////

	assign port.job_request = (state == cu_wait_job) && port.enable;

	// Tag is filled in by the arbiter from the port index
	assign port.read_command = '{
		valid:   (state == cu_issue),
		address: next_address,
		tag:     '0
	};

	assign port.edge_write = '{
		valid:     (state == cu_write),
		vertex_id: vertex_id,
		value:     sum
	};

endmodule

`default_nettype wire

/* verilog/vertex_arbiter_control.sv */
/*
 * Cluster arbiter
 * Job dispatch to the lowest waiting unit, round-robin read
 * and write grants, read data routing by tag, done counters
 */

`timescale 1ns/1ps
`default_nettype none

module vertex_arbiter_control (
	input  logic                                    clock,
	input  logic                                    rstn_input,
	input  logic                                    enabled_in,
	input  logic [vertex_cluster_pkg::num_cu-1:0]   cu_mask,
	input  vertex_cluster_pkg::vertex_job_t         job_in,
	input  logic                                    read_ready,
	input  vertex_cluster_pkg::read_data_t          read_data_in,
	input  logic                                    write_ready,
	output logic                                    job_request,
	output vertex_cluster_pkg::read_command_t       read_command_out,
	output vertex_cluster_pkg::edge_write_t         edge_write_out,
	output logic [vertex_cluster_pkg::count_bits-1:0] vertex_done_count,
	output logic [vertex_cluster_pkg::count_bits-1:0] edge_done_count,
	cu_port_if.arbiter                              cus [vertex_cluster_pkg::num_cu]
);
	import vertex_cluster_pkg::*;

	arb_state_t          arb_state;
	vertex_job_t         dispatch_job;
	logic [tag_bits-1:0] dispatch_sel;
	logic [num_cu-1:0]   job_pulse;
	logic [num_cu-1:0]   job_waiting;
	logic [num_cu-1:0]   waiting;

	logic [num_cu-1:0]    read_req;
	logic [edge_bits-1:0] read_address [num_cu];
	logic [num_cu-1:0]    read_grant;
	logic [tag_bits-1:0]  read_last;
	logic [tag_bits-1:0]  read_pick;
	logic                 read_go;

	edge_write_t          write_cu [num_cu];
	logic [num_cu-1:0]    write_req;
	logic [num_cu-1:0]    write_grant;
	logic [tag_bits-1:0]  write_last;
	logic [tag_bits-1:0]  write_pick;
	logic                 write_go;

	logic [edge_bits-1:0] unit_edges [num_cu];
	logic [num_cu-1:0]    data_pulse;
	logic [data_bits-1:0] data_q;

	// First requester after the last grant, wrapping over the units
	function automatic logic [tag_bits-1:0] rr_pick(input logic [num_cu-1:0] req,
		input logic [tag_bits-1:0] last);
		logic [tag_bits-1:0] pick;
		logic [tag_bits-1:0] idx;
		pick = last;
		for (int k = num_cu; k >= 1; k--) begin
			idx = last + tag_bits'(k);
			if (req[idx]) begin
				pick = idx;
			end
		end
		return pick;
	endfunction

	function automatic logic [tag_bits-1:0] lowest_pick(input logic [num_cu-1:0] req);
		logic [tag_bits-1:0] pick;
		pick = '0;
		for (int k = num_cu - 1; k >= 0; k--) begin
			if (req[k]) begin
				pick = tag_bits'(k);
			end
		end
		return pick;
	endfunction

	//////////////////////////////
	// Port fan-out
	//////////////////////////////

	for (genvar i = 0; i < num_cu; i++) begin : g_port
		assign job_waiting[i]  = cus[i].job_request;
		assign read_req[i]     = cus[i].read_command.valid;
		assign read_address[i] = cus[i].read_command.address;
		assign write_cu[i]     = cus[i].edge_write;
		assign write_req[i]    = write_cu[i].valid;
		assign cus[i].read_grant  = read_grant[i];
		assign cus[i].write_grant = write_grant[i];
		assign cus[i].enable      = cu_mask[i];
		assign cus[i].job = '{
			valid:      job_pulse[i],
			vertex_id:  dispatch_job.vertex_id,
			edge_start: dispatch_job.edge_start,
			edge_count: dispatch_job.edge_count
		};
		assign cus[i].read_data = '{valid: data_pulse[i], data: data_q, tag: tag_bits'(i)};
	end

	//////////////////////////////
	// Job dispatch
	//////////////////////////////

	// A unit whose job pulse is out still shows its request for one cycle
	assign waiting     = job_waiting & cu_mask & ~job_pulse;
	assign job_request = (arb_state == arb_requested) && enabled_in;

	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			arb_state    <= arb_idle;
			dispatch_sel <= '0;
			job_pulse    <= '0;
		end else begin
			job_pulse <= '0;
			case (arb_state)
				arb_idle: begin
					if (enabled_in && |waiting) begin
						arb_state <= arb_requested;
					end
				end
				arb_requested: begin
					if (job_in.valid) begin
						dispatch_sel <= lowest_pick(waiting);
						arb_state    <= arb_dispatch;
					end
				end
				arb_dispatch: begin
					job_pulse[dispatch_sel] <= 1'b1;
					arb_state               <= arb_idle;
				end
				default: begin
					arb_state <= arb_idle;
				end
			endcase
		end
	end

	// Job payload and per-unit edge count for the done counter
	always_ff @(posedge clock) begin
		if (arb_state == arb_requested && job_in.valid) begin
			dispatch_job <= job_in;
		end
		if (arb_state == arb_dispatch) begin
			unit_edges[dispatch_sel] <= dispatch_job.edge_count;
		end
		data_q <= read_data_in.data;
	end

	//////////////////////////////
	// Read and write grants
	//////////////////////////////

	assign read_pick   = rr_pick(read_req, read_last);
	assign read_go     = enabled_in && read_ready && |read_req;
	assign read_grant  = read_go ? (num_cu'(1) << read_pick) : '0;
	assign write_pick  = rr_pick(write_req, write_last);
	assign write_go    = enabled_in && write_ready && |write_req;
	assign write_grant = write_go ? (num_cu'(1) << write_pick) : '0;

	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			read_last         <= tag_bits'(num_cu - 1);
			write_last        <= tag_bits'(num_cu - 1);
			read_command_out  <= '0;
			edge_write_out    <= '0;
			data_pulse        <= '0;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			if (read_go) begin
				read_last <= read_pick;
			end
			read_command_out <= '{valid: read_go, address: read_address[read_pick], tag: read_pick};
			if (write_go) begin
				write_last        <= write_pick;
				vertex_done_count <= vertex_done_count + 1'b1;
				edge_done_count   <= edge_done_count + count_bits'(unit_edges[write_pick]);
			end
			edge_write_out <= '{
				valid:     write_go,
				vertex_id: write_cu[write_pick].vertex_id,
				value:     write_cu[write_pick].value
			};
			// Route returned data by its tag
			for (int k = 0; k < num_cu; k++) begin
				data_pulse[k] <= read_data_in.valid && (read_data_in.tag == tag_bits'(k));
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/vertex_cluster_control.sv */
/*
 * Vertex cluster top level
 * Registered inputs and outputs, enable and mask latching,
 * unit reset, arbiter and compute unit instances
 */

`timescale 1ns/1ps
`default_nettype none

module vertex_cluster_control (
	input  logic                                      clock,
	input  logic                                      rstn_input,
	input  logic                                      enabled_in,
	input  logic [63:0]                               cu_configure,
	input  logic                                      vertex_job_valid,
	input  logic [vertex_cluster_pkg::vertex_bits-1:0] vertex_job_id,
	input  logic [vertex_cluster_pkg::edge_bits-1:0]  edge_start,
	input  logic [vertex_cluster_pkg::edge_bits-1:0]  edge_count,
	input  logic                                      read_ready,
	input  logic                                      read_data_valid,
	input  logic [vertex_cluster_pkg::data_bits-1:0]  read_data,
	input  logic [vertex_cluster_pkg::tag_bits-1:0]   read_data_tag,
	input  logic                                      write_ready,
	output logic                                      vertex_job_request,
	output logic                                      read_command_valid,
	output logic [vertex_cluster_pkg::edge_bits-1:0]  read_command_address,
	output logic [vertex_cluster_pkg::tag_bits-1:0]   read_command_tag,
	output logic                                      write_valid,
	output logic [vertex_cluster_pkg::vertex_bits-1:0] write_vertex_id,
	output logic [vertex_cluster_pkg::data_bits-1:0]  write_value,
	output logic [vertex_cluster_pkg::count_bits-1:0] vertex_done_count,
	output logic [vertex_cluster_pkg::count_bits-1:0] edge_done_count
);
	import vertex_cluster_pkg::*;

	logic                   enabled;
	logic                   cu_rstn;
	logic [num_cu-1:0]      cu_mask;
	logic                   job_valid_q;
	logic [vertex_bits-1:0] job_id_q;
	logic [edge_bits-1:0]   edge_start_q;
	logic [edge_bits-1:0]   edge_count_q;
	logic                   read_ready_q;
	logic                   write_ready_q;
	logic                   data_valid_q;
	logic [data_bits-1:0]   data_q;
	logic [tag_bits-1:0]    data_tag_q;

	vertex_job_t            job_in;
	read_data_t             read_data_in;
	logic                   job_request;
	read_command_t          read_command;
	edge_write_t            edge_write;
	logic [count_bits-1:0]  vertex_count;
	logic [count_bits-1:0]  edge_count_done;

	//////////////////////////////
	// Input registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			enabled       <= 1'b0;
			job_valid_q   <= 1'b0;
			read_ready_q  <= 1'b0;
			write_ready_q <= 1'b0;
			data_valid_q  <= 1'b0;
			cu_mask       <= '0;
		end else begin
			enabled     <= enabled_in;
			job_valid_q <= enabled && vertex_job_valid;
			// Returned data always lands so reads in flight survive a disable
			data_valid_q <= read_data_valid;
			if (enabled) begin
				read_ready_q  <= read_ready;
				write_ready_q <= write_ready;
				if (|cu_configure) begin
					cu_mask <= cu_configure[num_cu-1:0];
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		job_id_q     <= vertex_job_id;
		edge_start_q <= edge_start;
		edge_count_q <= edge_count;
		data_q       <= read_data;
		data_tag_q   <= read_data_tag;
	end

	assign job_in = '{
		valid:      job_valid_q,
		vertex_id:  job_id_q,
		edge_start: edge_start_q,
		edge_count: edge_count_q
	};
	assign read_data_in = '{valid: data_valid_q, data: data_q, tag: data_tag_q};

	//////////////////////////////
	// Arbiter and compute units
	//////////////////////////////

	cu_port_if ports [num_cu] ();

	reset_sync u_reset_sync (
		.clock      (clock),
		.rstn_input (rstn_input),
		.cu_rstn    (cu_rstn)
	);

	vertex_arbiter_control u_arbiter (
		.clock             (clock),
		.rstn_input        (rstn_input),
		.enabled_in        (enabled),
		.cu_mask           (cu_mask),
		.job_in            (job_in),
		.read_ready        (read_ready_q),
		.read_data_in      (read_data_in),
		.write_ready       (write_ready_q),
		.job_request       (job_request),
		.read_command_out  (read_command),
		.edge_write_out    (edge_write),
		.vertex_done_count (vertex_count),
		.edge_done_count   (edge_count_done),
		.cus               (ports)
	);

	for (genvar i = 0; i < num_cu; i++) begin : g_unit
		vertex_spmv_unit u_unit (
			.clock      (clock),
			.rstn_input (cu_rstn),
			.port       (ports[i])
		);
	end

	//////////////////////////////
	// Output registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			vertex_job_request   <= 1'b0;
			read_command_valid   <= 1'b0;
			read_command_address <= '0;
			read_command_tag     <= '0;
			write_valid          <= 1'b0;
			write_vertex_id      <= '0;
			write_value          <= '0;
			vertex_done_count    <= '0;
			edge_done_count      <= '0;
		end else begin
			vertex_job_request   <= job_request;
			read_command_valid   <= read_command.valid;
			read_command_address <= read_command.address;
			read_command_tag     <= read_command.tag;
			write_valid          <= edge_write.valid;
			write_vertex_id      <= edge_write.vertex_id;
			write_value          <= edge_write.value;
			vertex_done_count    <= vertex_count;
			edge_done_count      <= edge_count_done;
		end
	end

endmodule

`default_nettype wire

/* dv/vertex_cluster_asserts.sv */
/*
 * Arbiter protocol checks
 * Grants one-hot and only to requesting units, commands held
 * while read_ready is low, job request only with a unit waiting
 */

`timescale 1ns/1ps
`default_nettype none

module vertex_cluster_asserts (
	input logic                                  clock,
	input logic                                  rstn_input,
	input logic                                  read_ready,
	input logic [vertex_cluster_pkg::num_cu-1:0] read_req,
	input logic [vertex_cluster_pkg::num_cu-1:0] read_grant,
	input logic [vertex_cluster_pkg::num_cu-1:0] write_req,
	input logic [vertex_cluster_pkg::num_cu-1:0] write_grant,
	input logic [vertex_cluster_pkg::num_cu-1:0] waiting,
	input vertex_cluster_pkg::read_command_t     read_command_out,
	input logic                                  job_request
);

	// At most one grant, and never to a unit that does not ask
	read_grant_one_hot: assert property (
		@(posedge clock) disable iff (!rstn_input)
		$onehot0(read_grant) && ((read_grant & ~read_req) == '0)
	) else $error("read grant is not one-hot or goes to an idle unit");

	write_grant_one_hot: assert property (
		@(posedge clock) disable iff (!rstn_input)
		$onehot0(write_grant) && ((write_grant & ~write_req) == '0)
	) else $error("write grant is not one-hot or goes to an idle unit");

	// Held-off units keep their commands, nothing leaves the arbiter
	read_command_needs_ready: assert property (
		@(posedge clock) disable iff (!rstn_input)
		!read_ready |=> !read_command_out.valid &&
			((read_req & $past(read_req)) == $past(read_req))
	) else $error("read command issued or dropped while read_ready was low");

	// Quiet in reset, and only raised for a waiting enabled unit
	job_request_quiet_in_reset: assert property (
		@(posedge clock) job_request |-> rstn_input && (|waiting)
	) else $error("job request raised during reset or with no unit waiting");

endmodule

bind vertex_arbiter_control vertex_cluster_asserts u_asserts (
	.clock            (clock),
	.rstn_input       (rstn_input),
	.read_ready       (read_ready),
	.read_req         (read_req),
	.read_grant       (read_grant),
	.write_req        (write_req),
	.write_grant      (write_grant),
	.waiting          (waiting),
	.read_command_out (read_command_out),
	.job_request      (job_request)
);

`default_nettype wire

/* dv/tb_vertex_cluster.sv */
/*
 * Directed testbench for the vertex cluster
 * Job source, tagged memory model with random latency,
 * reference sums by vertex id, six directed tests
 */

`timescale 1ns/1ps
`default_nettype none

module tb_vertex_cluster;
	import vertex_cluster_pkg::*;

	logic                   clock;
	logic                   rstn_input;
	logic                   enabled_in;
	logic [63:0]            cu_configure;
	logic                   vertex_job_valid;
	logic [vertex_bits-1:0] vertex_job_id;
	logic [edge_bits-1:0]   edge_start;
	logic [edge_bits-1:0]   edge_count;
	logic                   read_ready;
	logic                   read_data_valid;
	logic [data_bits-1:0]   read_data;
	logic [tag_bits-1:0]    read_data_tag;
	logic                   write_ready;
	logic                   vertex_job_request;
	logic                   read_command_valid;
	logic [edge_bits-1:0]   read_command_address;
	logic [tag_bits-1:0]    read_command_tag;
	logic                   write_valid;
	logic [vertex_bits-1:0] write_vertex_id;
	logic [data_bits-1:0]   write_value;
	logic [count_bits-1:0]  vertex_done_count;
	logic [count_bits-1:0]  edge_done_count;

	vertex_job_t          job_q [$];
	logic [data_bits-1:0] exp_value [int];
	bit                   written [int];
	logic [2:0]           rr_hist;
	logic [2:0]           wr_hist;
	int  error_count = 0;
	int  err_base;
	int  tests_passed = 0;
	int  tests_failed = 0;
	int  writes_seen;
	int  cmd_count;
	int  test_edges;
	int  total_edges = 0;
	bit  ready_noise = 0;
	bit  tag_expect = 0;
	bit  silent_check = 0;
	logic [count_bits-1:0] base_vertices;
	logic [count_bits-1:0] base_edges;

	vertex_cluster_control UUT (
		.clock                (clock),
		.rstn_input           (rstn_input),
		.enabled_in           (enabled_in),
		.cu_configure         (cu_configure),
		.vertex_job_valid     (vertex_job_valid),
		.vertex_job_id        (vertex_job_id),
		.edge_start           (edge_start),
		.edge_count           (edge_count),
		.read_ready           (read_ready),
		.read_data_valid      (read_data_valid),
		.read_data            (read_data),
		.read_data_tag        (read_data_tag),
		.write_ready          (write_ready),
		.vertex_job_request   (vertex_job_request),
		.read_command_valid   (read_command_valid),
		.read_command_address (read_command_address),
		.read_command_tag     (read_command_tag),
		.write_valid          (write_valid),
		.write_vertex_id      (write_vertex_id),
		.write_value          (write_value),
		.vertex_done_count    (vertex_done_count),
		.edge_done_count      (edge_done_count)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////
	// Reference and checks
	//////////////////////////////

	function automatic logic [data_bits-1:0] word_at(input logic [edge_bits-1:0] addr);
		return data_bits'(addr) * 3 + 7;
	endfunction

	// Sum over the edge addresses, which wrap like the address counter
	function automatic logic [data_bits-1:0] expected_sum(input logic [edge_bits-1:0] start,
		input logic [edge_bits-1:0] count);
		logic [data_bits-1:0] total;
		logic [edge_bits-1:0] addr;
		total = '0;
		addr  = start;
		for (int i = 0; i < int'(count); i++) begin
			total = total + word_at(addr);
			addr  = addr + 1'b1;
		end
		return total;
	endfunction

	task automatic note_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic check_write(input edge_write_t got, input edge_write_t want);
		if (got.value !== want.value) begin
			$display("[FAIL] %0t ns: vertex %0d wrote %h, expected %h",
				$time, got.vertex_id, got.value, want.value);
			error_count++;
		end
	endtask

	task automatic check_count(input logic [count_bits-1:0] got,
		input logic [count_bits-1:0] want, input string what);
		if (got !== want) begin
			$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, want);
			error_count++;
		end
	endtask

	task automatic check_tag(input logic [tag_bits-1:0] got, input logic [tag_bits-1:0] want);
		if (got !== want) begin
			$display("[FAIL] %0t ns: read command tag %0d, expected %0d", $time, got, want);
			error_count++;
		end
	endtask

	//////////////////////////////
	// Job source, ready noise, memory
	//////////////////////////////

	// One job per rising edge of the request, or per high level not yet answered
	initial begin : job_source
		vertex_job_t job;
		logic        answered;
		vertex_job_valid = 1'b0;
		vertex_job_id    = '0;
		edge_start       = '0;
		edge_count       = '0;
		answered         = 1'b0;
		forever begin
			@(negedge clock);
			vertex_job_valid = 1'b0;
			if (!vertex_job_request) begin
				answered = 1'b0;
			end else if (!answered && job_q.size() > 0) begin
				job              = job_q.pop_front();
				vertex_job_valid = 1'b1;
				vertex_job_id    = job.vertex_id;
				edge_start       = job.edge_start;
				edge_count       = job.edge_count;
				answered         = 1'b1;
			end
		end
	end

	initial begin : ready_driver
		read_ready  = 1'b1;
		write_ready = 1'b1;
		forever begin
			@(negedge clock);
			read_ready  = ready_noise ? ($urandom_range(0, 3) != 0) : 1'b1;
			write_ready = ready_noise ? ($urandom_range(0, 3) != 0) : 1'b1;
		end
	end

	initial begin : memory_model
		logic [data_bits-1:0] data_q [num_cu][$];
		int                   due_q [num_cu][$];
		int                   now;
		int                   first;
		int                   pick;
		int                   tag;
		read_data_valid = 1'b0;
		read_data       = '0;
		read_data_tag   = '0;
		now             = 0;
		forever begin
			@(negedge clock);
			now++;
			if (read_command_valid) begin
				data_q[read_command_tag].push_back(word_at(read_command_address));
				due_q[read_command_tag].push_back(now + $urandom_range(1, 8));
			end
			// Random starting tag gives out of order return across tags
			read_data_valid = 1'b0;
			first = $urandom_range(0, num_cu - 1);
			pick  = -1;
			for (int k = 0; k < num_cu; k++) begin
				tag = (first + k) % num_cu;
				if (pick < 0 && due_q[tag].size() > 0 && due_q[tag][0] <= now) begin
					pick = tag;
				end
			end
			if (pick >= 0) begin
				read_data_valid = 1'b1;
				read_data       = data_q[pick].pop_front();
				read_data_tag   = tag_bits'(pick);
				void'(due_q[pick].pop_front());
			end
		end
	end

	//////////////////////////////
	// Output monitor
	//////////////////////////////

	// Ready seen at the input three edges before an output strobe
	initial begin : ready_history
		rr_hist = '0;
		wr_hist = '0;
		forever begin
			@(posedge clock);
			rr_hist = {rr_hist[1:0], read_ready};
			wr_hist = {wr_hist[1:0], write_ready};
		end
	end

	initial begin : output_monitor
		edge_write_t got;
		edge_write_t want;
		int          key;
		forever begin
			@(negedge clock);
			if (silent_check && (vertex_job_request || read_command_valid || write_valid)) begin
				note_error("cluster output active while disabled");
			end
			if (read_command_valid) begin
				cmd_count++;
				if (rr_hist[2] !== 1'b1) begin
					note_error("read command issued while read_ready was low");
				end
				if (tag_expect) begin
					check_tag(read_command_tag, tag_bits'(1));
				end
			end
			if (write_valid) begin
				if (wr_hist[2] !== 1'b1) begin
					note_error("result write issued while write_ready was low");
				end
				key  = int'(write_vertex_id);
				got  = '{valid: 1'b1, vertex_id: write_vertex_id, value: write_value};
				if (!exp_value.exists(key)) begin
					note_error($sformatf("write for unknown vertex %0d", key));
				end else if (written.exists(key)) begin
					note_error($sformatf("vertex %0d written more than once", key));
				end else begin
					written[key] = 1'b1;
					want = '{valid: 1'b1, vertex_id: write_vertex_id, value: exp_value[key]};
					check_write(got, want);
					writes_seen++;
				end
			end
		end
	end

	//////////////////////////////
	// Test helpers
	//////////////////////////////

	task automatic load_job(input logic [vertex_bits-1:0] id,
		input logic [edge_bits-1:0] start, input logic [edge_bits-1:0] count);
		vertex_job_t job;
		job = '{valid: 1'b1, vertex_id: id, edge_start: start, edge_count: count};
		exp_value[int'(id)] = expected_sum(start, count);
		test_edges  += int'(count);
		total_edges += int'(count);
		job_q.push_back(job);
	endtask

	task automatic begin_test();
		err_base      = error_count;
		writes_seen   = 0;
		cmd_count     = 0;
		test_edges    = 0;
		base_vertices = vertex_done_count;
		base_edges    = edge_done_count;
	endtask

	task automatic wait_writes(input int n);
		while (writes_seen < n) begin
			@(negedge clock);
		end
		repeat (20) @(negedge clock);
	endtask

	task automatic end_test(input string name);
		if (error_count == err_base) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed", name);
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic single_job_sum();
		begin_test();
		load_job(16'd101, 16'h0040, 16'd5);
		wait_writes(1);
		check_count(vertex_done_count - base_vertices, 1, "vertex_done_count");
		check_count(edge_done_count - base_edges, 5, "edge_done_count");
		end_test("single job");
	endtask

	task automatic random_job_batch();
		begin_test();
		for (int i = 0; i < 12; i++) begin
			load_job(vertex_bits'(200 + i), edge_bits'($urandom_range(0, 16'hf000)),
				edge_bits'($urandom_range(0, 20)));
		end
		wait_writes(12);
		check_count(vertex_done_count - base_vertices, 12, "vertex_done_count");
		check_count(edge_done_count - base_edges, count_bits'(test_edges), "edge_done_count");
		end_test("random batch");
	endtask

	task automatic zero_edge_job();
		begin_test();
		load_job(16'd301, 16'h1234, 16'd0);
		wait_writes(1);
		check_count(count_bits'(cmd_count), 0, "read commands");
		end_test("zero edge job");
	endtask

	// Only unit 1 enabled, a zero word must not clear the mask
	task automatic masked_unit_config();
		begin_test();
		cu_configure = 64'h2;
		repeat (4) @(negedge clock);
		cu_configure = 64'h0;
		repeat (4) @(negedge clock);
		tag_expect = 1'b1;
		for (int i = 0; i < 4; i++) begin
			load_job(vertex_bits'(400 + i), edge_bits'(16'h0100 * i), edge_bits'(3 + i));
		end
		wait_writes(4);
		tag_expect   = 1'b0;
		cu_configure = 64'hf;
		repeat (4) @(negedge clock);
		end_test("unit mask");
	endtask

	task automatic ready_backpressure();
		begin_test();
		ready_noise = 1'b1;
		for (int i = 0; i < 8; i++) begin
			load_job(vertex_bits'(500 + i), edge_bits'($urandom_range(0, 16'hf000)),
				edge_bits'($urandom_range(1, 15)));
		end
		wait_writes(8);
		ready_noise = 1'b0;
		repeat (5) @(negedge clock);
		check_count(vertex_done_count - base_vertices, 8, "vertex_done_count");
		check_count(edge_done_count - base_edges, count_bits'(test_edges), "edge_done_count");
		end_test("ready back-pressure");
	endtask

	task automatic enable_gating();
		logic [count_bits-1:0] held_vertices;
		logic [count_bits-1:0] held_edges;
		begin_test();
		enabled_in = 1'b0;
		repeat (5) @(negedge clock);
		silent_check  = 1'b1;
		held_vertices = vertex_done_count;
		held_edges    = edge_done_count;
		for (int i = 0; i < 4; i++) begin
			load_job(vertex_bits'(600 + i), edge_bits'(16'h2000 + 16'h10 * i), edge_bits'(2 + i));
		end
		repeat (40) @(negedge clock);
		silent_check = 1'b0;
		check_count(vertex_done_count, held_vertices, "held vertex_done_count");
		check_count(edge_done_count, held_edges, "held edge_done_count");
		enabled_in = 1'b1;
		wait_writes(4);
		check_count(vertex_done_count - base_vertices, 4, "vertex_done_count");
		end_test("enable gating");
	endtask

	//////////////////////////////
	// Sequence and watchdog
	//////////////////////////////

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= 2000 + 200 * total_edges) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the cluster did not finish its jobs in time");
		$display("Some tests failed");
		$finish;
	end

	initial begin : main_sequence
		void'($urandom(32'h31e9));
		rstn_input   = 1'b0;
		enabled_in   = 1'b1;
		cu_configure = 64'hf;
		repeat (10) @(negedge clock);
		rstn_input = 1'b1;
		repeat (12) @(negedge clock);
		single_job_sum();
		random_job_batch();
		zero_edge_job();
		masked_unit_config();
		ready_backpressure();
		enable_gating();
		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (error_count == 0 && tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
verilog/vertex_cluster_pkg.sv
verilog/cu_port_if.sv
verilog/reset_sync.sv
verilog/vertex_spmv_unit.sv
verilog/vertex_arbiter_control.sv
verilog/vertex_cluster_control.sv
dv/vertex_cluster_asserts.sv
dv/tb_vertex_cluster.sv
